//--- common/core_pkg.sv
package core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // funct3 codes for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 codes for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY2
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic [1:0] {OP2_RS2, OP2_IMM_I, OP2_IMM_U} op2_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

endpackage

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rd_addr1_i,
    input  logic [REG_ADDR_W-1:0] rd_addr2_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic                  wr_en_i,
    input  logic [XLEN-1:0]       wr_data_i,
    output logic [XLEN-1:0]       rd_data1_o,
    output logic [XLEN-1:0]       rd_data2_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Combinational read ports, x0 reads as zero
    always_comb begin
        if (rd_addr1_i == '0) begin
            rd_data1_o = '0;
        end else begin
            rd_data1_o = regs[rd_addr1_i];
        end
    end

    always_comb begin
        if (rd_addr2_i == '0) begin
            rd_data2_o = '0;
        end else begin
            rd_data2_o = regs[rd_addr2_i];
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  pc_sel_e         pc_sel_i,
    input  logic [XLEN-1:0] br_target_i,
    input  logic [XLEN-1:0] jal_target_i,
    input  logic [XLEN-1:0] jalr_target_i,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] next_pc_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next_raw;

    always_comb begin
        case (pc_sel_i)
            PC_BRANCH: pc_next_raw = br_target_i;
            PC_JAL:    pc_next_raw = jal_target_i;
            PC_JALR:   pc_next_raw = jalr_target_i;
            default:   pc_next_raw = pc_q + 32'd4;
        endcase
    end

    // Word aligned next PC, pinned to the reset vector during reset
    always_comb begin
        if (rst_i) begin
            next_pc_o = RESET_PC;
        end else begin
            next_pc_o = {pc_next_raw[XLEN-1:2], 2'b00};
        end
    end

    // Same value goes out as the fetch address so the word lines up with pc_q
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc_o;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- decode/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
    input  logic [31:0]           inst_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  op1_sel_e              op1_sel_i,
    input  op2_sel_e              op2_sel_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       op1_o,
    output logic [XLEN-1:0]       op2_o,
    output logic [XLEN-1:0]       br_target_o,
    output logic [XLEN-1:0]       jal_target_o,
    output logic [XLEN-1:0]       jalr_target_o,
    output logic                  br_eq_o,
    output logic                  br_lt_o,
    output logic                  br_ltu_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Register fields sit at fixed positions in every format
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Sign extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // Operand select
    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op1_o = pc_i;
            OP1_ZERO: op1_o = '0;
            default:  op1_o = rs1_data_i;
        endcase
    end

    always_comb begin
        case (op2_sel_i)
            OP2_IMM_I: op2_o = imm_i;
            OP2_IMM_U: op2_o = imm_u;
            default:   op2_o = rs2_data_i;
        endcase
    end

    // Branch compare flags
    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    // Jump and branch targets, low bits are cleared in fetch
    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    assign jalr_target_o = rs1_data_i + imm_i;

endmodule

//--- decode/control_logic.sv
`timescale 1ns/1ps

module control_logic import core_pkg::*; (
    input  logic [31:0] inst_i,
    input  logic        br_eq_i,
    input  logic        br_lt_i,
    input  logic        br_ltu_i,
    output alu_op_e     alu_op_o,
    output op1_sel_e    op1_sel_o,
    output op2_sel_e    op2_sel_o,
    output pc_sel_e     pc_sel_o,
    output wb_sel_e     wb_sel_o,
    output logic        rf_we_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       br_taken;
    logic       wr_req;
    alu_op_e    alu_f3;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // Branch outcome from funct3 and the compare flags
    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = br_eq_i;
            F3_BNE:  br_taken = !br_eq_i;
            F3_BLT:  br_taken = br_lt_i;
            F3_BGE:  br_taken = !br_lt_i;
            F3_BLTU: br_taken = br_ltu_i;
            F3_BGEU: br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    // ALU op shared by OP and OP-IMM, bit 30 picks SUB and SRA
    always_comb begin
        case (funct3)
            F3_SLL:  alu_f3 = ALU_SLL;
            F3_SLT:  alu_f3 = ALU_SLT;
            F3_SLTU: alu_f3 = ALU_SLTU;
            F3_XOR:  alu_f3 = ALU_XOR;
            F3_SR:   alu_f3 = inst_i[30] ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_f3 = ALU_OR;
            F3_AND:  alu_f3 = ALU_AND;
            default: alu_f3 = ALU_ADD;
        endcase
    end

    always_comb begin
        // Defaults retire the word as a no-op
        alu_op_o  = ALU_ADD;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        pc_sel_o  = PC_PLUS4;
        wb_sel_o  = WB_ALU;
        wr_req    = 1'b0;
        case (opcode_e'(inst_i[6:0]))
            OPC_LUI: begin
                op1_sel_o = OP1_ZERO;
                op2_sel_o = OP2_IMM_U;
                alu_op_o  = ALU_COPY2;
                wr_req    = 1'b1;
            end
            OPC_AUIPC: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_U;
                wr_req    = 1'b1;
            end
            OPC_JAL: begin
                pc_sel_o = PC_JAL;
                wb_sel_o = WB_PC4;
                wr_req   = 1'b1;
            end
            OPC_JALR: begin
                pc_sel_o = PC_JALR;
                wb_sel_o = WB_PC4;
                wr_req   = 1'b1;
            end
            OPC_BRANCH: begin
                pc_sel_o = br_taken ? PC_BRANCH : PC_PLUS4;
            end
            OPC_OP_IMM: begin
                op2_sel_o = OP2_IMM_I;
                // Only SRAI may set bit 30 among the shift immediates
                if (funct3 == F3_SLL) begin
                    wr_req   = (funct7 == 7'h00);
                    alu_op_o = ALU_SLL;
                end else if (funct3 == F3_SR) begin
                    wr_req   = (funct7 == 7'h00) || (funct7 == 7'h20);
                    alu_op_o = alu_f3;
                end else begin
                    wr_req   = 1'b1;
                    alu_op_o = alu_f3;
                end
            end
            OPC_OP: begin
                alu_op_o = ((funct3 == F3_ADD) && inst_i[30]) ? ALU_SUB : alu_f3;
                wr_req   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // x0 destinations never write
    assign rf_we_o = wr_req && (inst_i[11:7] != 5'd0);

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    input  alu_op_e         alu_op_i,
    input  wb_sel_e         wb_sel_i,
    input  logic [XLEN-1:0] pc_i,
    output logic [XLEN-1:0] wr_data_o
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_plus4;
    logic [4:0]      shamt;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_result = op1_i + op2_i;
            ALU_SUB:   alu_result = op1_i - op2_i;
            ALU_SLL:   alu_result = op1_i << shamt;
            ALU_SLT:   alu_result = {31'b0, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:  alu_result = {31'b0, op1_i < op2_i};
            ALU_XOR:   alu_result = op1_i ^ op2_i;
            ALU_SRL:   alu_result = op1_i >> shamt;
            ALU_SRA:   alu_result = $unsigned($signed(op1_i) >>> shamt);
            ALU_OR:    alu_result = op1_i | op2_i;
            ALU_AND:   alu_result = op1_i & op2_i;
            ALU_COPY2: alu_result = op2_i;
            default:   alu_result = '0;
        endcase
    end

    // Return address for JAL and JALR
    assign pc_plus4 = pc_i + 32'd4;

    // Write-back select
    always_comb begin
        if (wb_sel_i == WB_PC4) begin
            wr_data_o = pc_plus4;
        end else begin
            wr_data_o = alu_result;
        end
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    // Instruction memory, word returns one edge after the address
    output logic [XLEN-1:0]       imem_addr_o,
    input  logic [31:0]           imem_rdata_i,
    // Retire trace
    output logic [XLEN-1:0]       retire_pc_o,
    output logic                  retire_we_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_wdata_o
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       br_target;
    logic [XLEN-1:0]       jal_target;
    logic [XLEN-1:0]       jalr_target;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       wr_data;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  br_eq;
    logic                  br_lt;
    logic                  br_ltu;
    logic                  rf_we;
    logic                  rf_wr_en;
    alu_op_e               alu_op;
    op1_sel_e              op1_sel;
    op2_sel_e              op2_sel;
    pc_sel_e               pc_sel;
    wb_sel_e               wb_sel;

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .pc_sel_i      (pc_sel),
        .br_target_i   (br_target),
        .jal_target_i  (jal_target),
        .jalr_target_i (jalr_target),
        .pc_o          (pc),
        .next_pc_o     (next_pc)
    );

    decode_unit decode_unit_i (
        .inst_i        (imem_rdata_i),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .op1_sel_i     (op1_sel),
        .op2_sel_i     (op2_sel),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op1_o         (op1),
        .op2_o         (op2),
        .br_target_o   (br_target),
        .jal_target_o  (jal_target),
        .jalr_target_o (jalr_target),
        .br_eq_o       (br_eq),
        .br_lt_o       (br_lt),
        .br_ltu_o      (br_ltu)
    );

    control_logic control_logic_i (
        .inst_i    (imem_rdata_i),
        .br_eq_i   (br_eq),
        .br_lt_i   (br_lt),
        .br_ltu_i  (br_ltu),
        .alu_op_o  (alu_op),
        .op1_sel_o (op1_sel),
        .op2_sel_o (op2_sel),
        .pc_sel_o  (pc_sel),
        .wb_sel_o  (wb_sel),
        .rf_we_o   (rf_we)
    );

    execute_unit execute_unit_i (
        .op1_i     (op1),
        .op2_i     (op2),
        .alu_op_i  (alu_op),
        .wb_sel_i  (wb_sel),
        .pc_i      (pc),
        .wr_data_o (wr_data)
    );

    // No register writes retire while in reset
    assign rf_wr_en = rf_we && !rst_i;

    register_file register_file_i (
        .clk        (clk),
        .rd_addr1_i (rs1_addr),
        .rd_addr2_i (rs2_addr),
        .wr_addr_i  (rd_addr),
        .wr_en_i    (rf_wr_en),
        .wr_data_i  (wr_data),
        .rd_data1_o (rs1_data),
        .rd_data2_o (rs2_data)
    );

    assign imem_addr_o    = next_pc;
    assign retire_pc_o    = pc;
    assign retire_we_o    = rf_wr_en;
    assign retire_rd_o    = rd_addr;
    assign retire_wdata_o = wr_data;

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import core_pkg::*; ();

    localparam int IMEM_WORDS    = 256;
    localparam int RUN_CYCLES    = 3000;
    localparam int RESET_CYCLES  = 10;

    logic                  clk;
    logic                  rst_i;
    logic [XLEN-1:0]       imem_addr_o;
    logic [31:0]           imem_rdata_i;
    logic [XLEN-1:0]       retire_pc_o;
    logic                  retire_we_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_wdata_o;

    logic [31:0]     imem [IMEM_WORDS];
    logic [31:0]     lfsr_state;

    // Reference ISA state, x0 stays zero
    logic [XLEN-1:0] model_pc;
    logic [XLEN-1:0] model_regs [32];

    rv_core rv_core_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Synchronous instruction memory, addresses wrap on bits 9:2
    initial begin
        imem_rdata_i <= '0;
        forever begin
            @(posedge clk);
            imem_rdata_i <= imem[imem_addr_o[9:2]];
        end
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [19:0] upper;
        logic [11:0] imm12;
        logic [6:0]  imm_hi;
        logic [4:0]  imm_lo;
        logic        alt;
        logic [31:0] word;
        kind   = 3'(take_bits(3));
        rd     = 5'(take_bits(5));
        rs1    = 5'(take_bits(5));
        rs2    = 5'(take_bits(5));
        funct3 = 3'(take_bits(3));
        case (kind)
            3'd0: begin
                upper = 20'(take_bits(20));
                word  = {upper, rd, OPC_LUI};
            end
            3'd1: begin
                upper = 20'(take_bits(20));
                word  = {upper, rd, OPC_AUIPC};
            end
            3'd2: begin
                upper = 20'(take_bits(20));
                word  = {upper, rd, OPC_JAL};
            end
            3'd3: begin
                imm12 = 12'(take_bits(12));
                word  = {imm12, rs1, 3'b000, rd, OPC_JALR};
            end
            3'd4: begin
                imm_hi = 7'(take_bits(7));
                imm_lo = 5'(take_bits(5));
                word   = {imm_hi, rs2, rs1, funct3, imm_lo, OPC_BRANCH};
            end
            3'd5: begin
                imm12 = 12'(take_bits(12));
                // Mostly clean shift encodings, the rest stay random
                if ((funct3 == 3'b001 || funct3 == 3'b101) && take_bits(2) != 0) begin
                    alt          = 1'(take_bits(1));
                    imm12[11:5] = {1'b0, alt, 5'b00000};
                end
                word = {imm12, rs1, funct3, rd, OPC_OP_IMM};
            end
            3'd6: begin
                alt  = 1'(take_bits(1));
                word = {1'b0, alt, 5'b00000, rs2, rs1, funct3, rd, OPC_OP};
            end
            default: begin
                word = take_bits(32);
                case (word[6:0])
                    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                    OPC_BRANCH, OPC_OP_IMM, OPC_OP: word[6:0] = 7'b0000011;
                    default: begin
                    end
                endcase
            end
        endcase
        return word;
    endfunction

    task automatic fill_imem();
        logic [11:0] imm12;
        for (int idx = 0; idx < IMEM_WORDS; idx++) begin
            if (idx < 31) begin
                // ADDI x(idx+1), x0, imm
                imm12     = 12'(take_bits(12));
                imem[idx] = {imm12, 5'd0, 3'b000, 5'(idx + 1), OPC_OP_IMM};
            end else begin
                imem[idx] = random_instruction();
            end
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] funct3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] shifted;
        case (funct3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    shifted = $signed(a) >>> b[4:0];
                end else begin
                    shifted = a >> b[4:0];
                end
                return shifted;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes the word at model_pc without touching model state
    task automatic predict(output logic exp_we, output logic [4:0] exp_rd,
                           output logic [31:0] exp_wdata, output logic [31:0] exp_next);
        logic [31:0] inst;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic        wr_req;
        logic        taken;
        inst      = imem[model_pc[9:2]];
        funct3    = inst[14:12];
        funct7    = inst[31:25];
        rs1_val   = model_regs[inst[19:15]];
        rs2_val   = model_regs[inst[24:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u     = {inst[31:12], 12'h000};
        imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        wr_req    = 1'b0;
        taken     = 1'b0;
        exp_wdata = '0;
        exp_next  = model_pc + 32'd4;
        case (inst[6:0])
            OPC_LUI: begin
                wr_req    = 1'b1;
                exp_wdata = imm_u;
            end
            OPC_AUIPC: begin
                wr_req    = 1'b1;
                exp_wdata = model_pc + imm_u;
            end
            OPC_JAL: begin
                wr_req    = 1'b1;
                exp_wdata = model_pc + 32'd4;
                exp_next  = model_pc + imm_j;
            end
            OPC_JALR: begin
                wr_req    = 1'b1;
                exp_wdata = model_pc + 32'd4;
                exp_next  = rs1_val + imm_i;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  taken = (rs1_val == rs2_val);
                    3'b001:  taken = (rs1_val != rs2_val);
                    3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
                    3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
                    3'b110:  taken = (rs1_val < rs2_val);
                    3'b111:  taken = (rs1_val >= rs2_val);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    exp_next = model_pc + imm_b;
                end
            end
            OPC_OP_IMM: begin
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001) begin
                    wr_req = (funct7 == 7'h00);
                end else if (funct3 == 3'b101) begin
                    wr_req = (funct7 == 7'h00) || (funct7 == 7'h20);
                end else begin
                    wr_req = 1'b1;
                end
                exp_wdata = alu_model(funct3, (funct3 == 3'b101) && inst[30], rs1_val, imm_i);
            end
            OPC_OP: begin
                wr_req    = 1'b1;
                exp_wdata = alu_model(funct3, inst[30], rs1_val, rs2_val);
            end
            default: begin
            end
        endcase
        exp_rd   = inst[11:7];
        exp_we   = wr_req && (inst[11:7] != 5'd0);
        exp_next = {exp_next[31:2], 2'b00};
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    initial begin
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_wdata;
        logic [31:0] exp_next;
        lfsr_state  = 32'hbe16;
        rst_i      <= 1'b1;
        fill_imem();
        model_pc = RESET_PC;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        // Core must hold the reset vector and write nothing
        for (int cycle = 0; cycle < RESET_CYCLES; cycle++) begin
            @(negedge clk);
            check_value("retire_we_o", 32'(retire_we_o), 32'd0);
            check_value("retire_pc_o", retire_pc_o, RESET_PC);
            check_value("imem_addr_o", imem_addr_o, RESET_PC);
            @(posedge clk);
        end
        rst_i <= 1'b0;

        // First instruction retires in the first cycle after reset
        @(negedge clk);

        // Lockstep compare, one retired instruction per cycle
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            predict(exp_we, exp_rd, exp_wdata, exp_next);
            check_value("retire_pc_o", retire_pc_o, model_pc);
            check_value("retire_we_o", 32'(retire_we_o), 32'(exp_we));
            check_value("retire_rd_o", 32'(retire_rd_o), 32'(exp_rd));
            if (exp_we) begin
                check_value("retire_wdata_o", retire_wdata_o, exp_wdata);
                model_regs[exp_rd] = exp_wdata;
            end
            check_value("imem_addr_o", imem_addr_o, exp_next);
            model_pc = exp_next;
            @(negedge clk);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sources.f
common/core_pkg.sv
logic/register_file.sv
logic/fetch_unit.sv
decode/decode_unit.sv
decode/control_logic.sv
logic/execute_unit.sv
logic/rv_core.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_rv_core
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f sources.f -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -qxF "All tests passed!" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
